// File: verilog/lcd_pkg.sv
package lcd_pkg;

	// display setup bits, msb first as they appear in the init commands
	typedef struct packed {
		logic display_lines;	// N, 1 selects two lines
		logic font;				// F, 1 selects 5x10 dots
		logic display_on;		// D
		logic cursor;			// C
		logic blink;			// B
		logic inc_dec;			// I/D, 1 increments the address
		logic shift;			// S, shift whole display on write
	} lcd_cfg_t;

	// one host transfer
	typedef struct packed {
		logic       rs;			// 0 instruction, 1 data register
		logic       rw;			// passed to the pin only
		logic [7:0] data;
	} lcd_xfer_t;

	// values on the lcd connector
	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	// timing in microseconds, scaled by CLK_PER_US in the controller
	localparam int POWERUP_US      = 500;	// vdd settle before first command
	localparam int CMD_E_US        = 10;	// enable width of an init command
	localparam int WAIT_SHORT_US   = 50;	// after function set and display control
	localparam int WAIT_CLEAR_US   = 200;	// clear is the slowest command
	localparam int WAIT_ENTRY_US   = 100;	// after entry mode set
	localparam int XFER_US         = 50;	// whole host transfer window
	localparam int XFER_E_START_US = 1;		// address setup before e rises
	localparam int XFER_E_END_US   = 14;	// e falls here, rest is hold

	localparam int INIT_STEPS      = 4;

endpackage

// File: verilog/lcd_ctrl.sv
module lcd_ctrl
	import lcd_pkg::*;
#(
	parameter int CLK_PER_US = 50
) (
	input  logic      clk,
	input  logic      arst_n,
	input  lcd_cfg_t  cfg,
	input  logic      pending,
	input  lcd_xfer_t cmd,
	output logic      taken,
	output logic      done,
	output logic      ready,
	output lcd_pins_t pins
);

	localparam int POWERUP_CYC = POWERUP_US * CLK_PER_US;
	localparam int CMD_E_CYC   = CMD_E_US * CLK_PER_US;
	localparam int XFER_CYC    = XFER_US * CLK_PER_US;
	localparam int E_START_CYC = XFER_E_START_US * CLK_PER_US;
	localparam int E_END_CYC   = XFER_E_END_US * CLK_PER_US;
	localparam int CNT_W       = $clog2(POWERUP_CYC + 1);	// power-up is the longest count

	typedef enum logic [1:0] {
		ST_POWERUP,
		ST_INIT,
		ST_READY,
		ST_XFER
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;		// cycles into the current phase
	logic [1:0]       step;		// init command index
	logic [1:0]       step_nxt;
	logic             in_wait;	// init phase, 0 enable high, 1 wait

	// command byte of an init step
	function automatic logic [7:0] init_byte(input logic [1:0] idx, input lcd_cfg_t c);
		case (idx)
			2'd0:    init_byte = {4'b0011, c.display_lines, c.font, 2'b00};	// function set
			2'd1:    init_byte = {5'b00001, c.display_on, c.cursor, c.blink};	// on/off ctrl
			2'd2:    init_byte = 8'b0000_0001;								// clear
			default: init_byte = {6'b000001, c.inc_dec, c.shift};			// entry mode
		endcase
	endfunction

	// last cycle of the wait that follows an init step
	function automatic logic [CNT_W-1:0] wait_last(input logic [1:0] idx);
		int us;
		case (idx)
			2'd0, 2'd1: us = WAIT_SHORT_US;
			2'd2:       us = WAIT_CLEAR_US;
			default:    us = WAIT_ENTRY_US;
		endcase
		wait_last = CNT_W'(us * CLK_PER_US - 1);
	endfunction

	assign step_nxt = step + 2'd1;

	// accept straight away once the bus is idle
	assign taken = (state == ST_READY) && pending;
	assign done  = (state == ST_XFER) && (cnt == CNT_W'(XFER_CYC - 1));
	assign ready = (state == ST_READY) || (state == ST_XFER);	// no way back short of reset

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_POWERUP;
			cnt     <= '0;
			step    <= '0;
			in_wait <= 1'b0;
			pins    <= '0;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt == CNT_W'(POWERUP_CYC - 1)) begin
						// first command goes out with e already high
						state   <= ST_INIT;
						cnt     <= '0;
						step    <= 2'd0;
						in_wait <= 1'b0;
						pins    <= '{e: 1'b1, rs: 1'b0, rw: 1'b0, data: init_byte(2'd0, cfg)};
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				ST_INIT: begin
					if (!in_wait) begin
						if (cnt == CNT_W'(CMD_E_CYC - 1)) begin
							in_wait <= 1'b1;
							cnt     <= '0;
							pins    <= '0;	// bus parked low during the wait
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (cnt == wait_last(step)) begin
						cnt     <= '0;
						in_wait <= 1'b0;
						if (step == 2'(INIT_STEPS - 1)) begin
							state <= ST_READY;
						end else begin
							step <= step_nxt;
							pins <= '{e: 1'b1, rs: 1'b0, rw: 1'b0,
								data: init_byte(step_nxt, cfg)};
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				ST_READY: begin
					if (pending) begin
						state <= ST_XFER;
						cnt   <= '0;
						// rs/rw/data set up ahead of e
						pins  <= '{e: 1'b0, rs: cmd.rs, rw: cmd.rw, data: cmd.data};
					end
				end

				ST_XFER: begin
					if (cnt == CNT_W'(XFER_CYC - 1)) begin
						state <= ST_READY;
						cnt   <= '0;
						pins  <= '0;
					end else begin
						cnt <= cnt + 1'b1;
						if (cnt == CNT_W'(E_START_CYC - 1)) begin
							pins.e <= 1'b1;
						end else if (cnt == CNT_W'(E_END_CYC - 1)) begin
							pins.e <= 1'b0;	// bus stays put for hold
						end
					end
				end

				default: begin
					state <= ST_POWERUP;
					cnt   <= '0;
				end
			endcase
		end
	end

endmodule

// File: verilog/lcd_host_port.sv
module lcd_host_port
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      req,
	input  lcd_xfer_t xfer,
	input  logic      taken,
	input  logic      done,
	output logic      ack,
	output logic      pending,
	output lcd_xfer_t cmd
);

	typedef enum logic [1:0] {
		HP_IDLE,
		HP_WAIT_TAKE,
		HP_WAIT_DONE,
		HP_ACK_HIGH
	} hp_state_t;

	hp_state_t state;
	hp_state_t state_nxt;
	logic      accept;

	// new request only after the previous one has been fully released
	assign accept = (state == HP_IDLE) && req;

	always_comb begin
		state_nxt = state;
		case (state)
			HP_IDLE:      if (accept) state_nxt = HP_WAIT_TAKE;
			HP_WAIT_TAKE: if (taken)  state_nxt = HP_WAIT_DONE;
			HP_WAIT_DONE: if (done)   state_nxt = HP_ACK_HIGH;
			HP_ACK_HIGH:  if (!req)   state_nxt = HP_IDLE;
			default:                  state_nxt = HP_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= HP_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// transfer word held for the controller
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd <= xfer;
		end
	end

	assign pending = (state == HP_WAIT_TAKE);	// waits out init as well
	assign ack     = (state == HP_ACK_HIGH);

endmodule

// File: verilog/lcd_subsys.sv
module lcd_subsys
	import lcd_pkg::*;
#(
	parameter int CLK_PER_US = 50
) (
	input  logic      clk,
	input  logic      arst_n,
	input  lcd_cfg_t  cfg,
	input  logic      req,
	input  lcd_xfer_t xfer,
	output logic      ack,
	output logic      ready,
	output lcd_pins_t pins
);

	logic      pending;
	logic      taken;
	logic      done;
	lcd_xfer_t cmd;

	// host handshake side
	lcd_host_port u_host_port (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.xfer    (xfer),
		.taken   (taken),
		.done    (done),
		.ack     (ack),
		.pending (pending),
		.cmd     (cmd)
	);

	// pin side, timing scaled by the clock rate
	lcd_ctrl #(
		.CLK_PER_US (CLK_PER_US)
	) u_ctrl (
		.clk     (clk),
		.arst_n  (arst_n),
		.cfg     (cfg),
		.pending (pending),
		.cmd     (cmd),
		.taken   (taken),
		.done    (done),
		.ready   (ready),
		.pins    (pins)
	);

endmodule

// File: verif/lcd_subsys_props.sv
module lcd_subsys_props
	import lcd_pkg::*;
(
	input logic      clk,
	input logic      arst_n,
	input logic      req,
	input logic      ack,
	input logic      ready,
	input lcd_pins_t pins
);
	timeunit 1ns;
	timeprecision 100ps;

	int err_cnt = 0;	// failure count, read by the testbench

	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> req)
		else begin
			err_cnt++;
			$error("ack rose without req");
		end

	// four-phase release
	ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(ack) |-> $past(!req))
		else begin
			err_cnt++;
			$error("ack fell while req was still high");
		end

	bus_stable_during_e: assert property (@(posedge clk) disable iff (!arst_n)
		(pins.e && $past(pins.e)) |-> $stable({pins.rs, pins.rw, pins.data}))
		else begin
			err_cnt++;
			$error("lcd bus changed while e was high");
		end

	ready_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		!$fell(ready))
		else begin
			err_cnt++;
			$error("ready dropped without reset");
		end

endmodule

bind lcd_subsys lcd_subsys_props u_props (
	.clk    (clk),
	.arst_n (arst_n),
	.req    (req),
	.ack    (ack),
	.ready  (ready),
	.pins   (pins)
);

// File: verif/lcd_subsys_tb.sv
module lcd_subsys_tb
	import lcd_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int U          = 2;	// clock cycles per microsecond
	localparam int CLK_NS     = 10;
	localparam int N_XFER     = 40;
	localparam int INIT_CYC   = (POWERUP_US + 4 * CMD_E_US + 2 * WAIT_SHORT_US
		+ WAIT_CLEAR_US + WAIT_ENTRY_US) * U;	// reset release to ready
	localparam int XFER_WORST = XFER_US * U + 20 + 5 + 8;	// window, gap, release, handshake
	localparam int ABORT_MAX  = 4000;
	localparam int LIMIT_CYC  = 2 * (INIT_CYC + 12) + 2 * N_XFER * XFER_WORST + ABORT_MAX;

	logic      clk;
	logic      arst_n;
	lcd_cfg_t  cfg;
	logic      req;
	lcd_xfer_t xfer;
	logic      ack;
	logic      ready;
	lcd_pins_t pins;

	int        seed;
	logic      abort;
	int        abort_cyc;	// traffic cycles before the mid-run reset
	lcd_xfer_t exp_q[$];	// expected bus words, init commands first
	int        data_errs;
	int        timing_errs;
	int        proto_errs;

	// pin monitor state
	int        cyc;			// cycles since reset release
	int        pulse_idx;	// enable pulses since reset
	int        high_cnt;
	int        last_rise;
	logic      e_prev;
	logic      ready_prev;
	lcd_pins_t prev_pins;
	lcd_xfer_t exp_w;

	lcd_subsys #(
		.CLK_PER_US (U)
	) dut (
		.clk    (clk),
		.arst_n (arst_n),
		.cfg    (cfg),
		.req    (req),
		.xfer   (xfer),
		.ack    (ack),
		.ready  (ready),
		.pins   (pins)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic int rand_range(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check_value(input string name, input int exp_v, input int act_v);
		assert (exp_v == act_v) else begin
			data_errs++;
			$display("Fail %0t %s expected 0x%0h got 0x%0h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_cycles(input string name, input int exp_v, input int act_v);
		assert (exp_v == act_v) else begin
			timing_errs++;
			$display("Fail %0t %s expected %0d cycles got %0d", $time, name, exp_v, act_v);
		end
	endtask

	// command bytes straight from the HD44780 instruction table
	task automatic push_init_words(input lcd_cfg_t c);
		exp_q.push_back({2'b00, 4'b0011, c.display_lines, c.font, 2'b00});
		exp_q.push_back({2'b00, 5'b00001, c.display_on, c.cursor, c.blink});
		exp_q.push_back({2'b00, 8'b0000_0001});
		exp_q.push_back({2'b00, 6'b000001, c.inc_dec, c.shift});
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		req    = 1'b0;
		cfg    = lcd_cfg_t'($random(seed));
		exp_q.delete();
		push_init_words(cfg);
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
	endtask

	task automatic run_traffic(input int n);
		int        gap;
		int        hold;
		lcd_xfer_t x;
		for (int i = 0; i < n && !abort; i++) begin
			gap = rand_range(21);
			repeat (gap) @(posedge clk);
			@(posedge clk);
			#1;
			x    = lcd_xfer_t'($random(seed));
			xfer = x;
			req  = 1'b1;
			exp_q.push_back(x);
			@(posedge clk);
			while (!ack && !abort) @(posedge clk);
			if (abort) break;	// req stays up until the reset takes it down
			assert (exp_q.size() == 0) else begin
				proto_errs++;
				$display("ack at %0t came before the transfer was seen on the pins", $time);
			end
			hold = rand_range(6);	// host lingers before release
			repeat (hold) @(posedge clk);
			#1 req = 1'b0;
			@(posedge clk);
			while (ack) @(posedge clk);
		end
	endtask

	// samples before the edge, so registered pins are settled
	always @(posedge clk) begin
		if (!arst_n) begin
			cyc        = 0;
			pulse_idx  = 0;
			high_cnt   = 0;
			last_rise  = -1;
			e_prev     = 1'b0;
			ready_prev = 1'b0;
			prev_pins  = '0;
		end else begin
			if (pins.e && !e_prev) begin
				high_cnt = 0;
				if (pulse_idx == 0) begin
					check_cycles("pins.e first rise", POWERUP_US * U, cyc);
				end else if (pulse_idx >= 4) begin
					if (last_rise >= 0) begin
						assert (cyc - last_rise >= XFER_US * U) else begin
							timing_errs++;
							$display("Fail %0t pins.e spacing expected >= %0d got %0d",
								$time, XFER_US * U, cyc - last_rise);
						end
					end
					last_rise = cyc;
				end
			end
			if (pins.e) high_cnt++;
			if (!pins.e && e_prev) begin
				if (pulse_idx < 4) begin
					check_cycles("pins.e init width", CMD_E_US * U, high_cnt);
				end else begin
					check_cycles("pins.e xfer width",
						(XFER_E_END_US - XFER_E_START_US) * U, high_cnt);
				end
				if (exp_q.size() == 0) begin
					proto_errs++;
					$display("enable pulse at %0t with no transfer expected", $time);
				end else begin
					exp_w = exp_q.pop_front();
					check_value("pins.rs", exp_w.rs, prev_pins.rs);
					check_value("pins.rw", exp_w.rw, prev_pins.rw);
					check_value("pins.data", exp_w.data, prev_pins.data);
				end
				pulse_idx++;
			end
			if (ready && !ready_prev) check_cycles("ready rise", INIT_CYC, cyc);
			assert (!ready || pulse_idx >= 4) else begin
				proto_errs++;
				$display("ready high at %0t before the init commands went out", $time);
			end
			assert (!ack || ready) else begin
				proto_errs++;
				$display("ack high at %0t while init still runs", $time);
			end
			e_prev     = pins.e;
			prev_pins  = pins;
			ready_prev = ready;
			cyc++;
		end
	end

	initial begin
		#(LIMIT_CYC * CLK_NS);
		$display("run timed out after %0d cycles without finishing", LIMIT_CYC);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		seed        = 32'h1d14_cce9;
		clk         = 1'b0;
		arst_n      = 1'b0;
		cfg         = '0;
		req         = 1'b0;
		xfer        = '0;
		abort       = 1'b0;
		data_errs   = 0;
		timing_errs = 0;
		proto_errs  = 0;

		apply_reset();
		abort_cyc = 2000 + rand_range(ABORT_MAX - 2000);
		fork
			run_traffic(N_XFER);
			begin
				repeat (abort_cyc) @(posedge clk);
				#1 abort = 1'b1;	// cut the traffic short for a mid-run reset
			end
		join
		apply_reset();
		abort = 1'b0;
		run_traffic(N_XFER);
		repeat (20) @(posedge clk);
		assert (exp_q.size() == 0) else begin
			proto_errs++;
			$display("%0d expected bus words never showed up", exp_q.size());
		end

		$display("errors: %0d value, %0d timing, %0d protocol, %0d assertion",
			data_errs, timing_errs, proto_errs, dut.u_props.err_cnt);
		if (data_errs + timing_errs + proto_errs + dut.u_props.err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: lcd_subsys.f
verilog/lcd_pkg.sv
verilog/lcd_ctrl.sv
verilog/lcd_host_port.sv
verilog/lcd_subsys.sv
verif/lcd_subsys_props.sv
verif/lcd_subsys_tb.sv

// File: Bender.yml
package:
  name: lcd_subsys

sources:
  - verilog/lcd_pkg.sv
  - verilog/lcd_ctrl.sv
  - verilog/lcd_host_port.sv
  - verilog/lcd_subsys.sv
  - target: test
    files:
      - verif/lcd_subsys_props.sv
      - verif/lcd_subsys_tb.sv
